/* common/sifhPkg.sv */
`default_nettype none

package sifhPkg;

    localparam int NB          = 4;            // coarse bin width, 16 bins
    localparam int NP          = 10;           // fine time width
    localparam int PIXEL_NUM   = 8;            // pixels per frame
    localparam int PIXEL_W     = $clog2(PIXEL_NUM);
    localparam int COUNT_W     = 8;            // counters saturate at 255
    localparam int BIN_NUM     = 1 << NB;
    localparam int FINE_SHIFT  = NP - NB;      // coarse to fine scaling
    localparam int BIN_WIDTH   = 1 << FINE_SHIFT;  // 64 fine steps per bin
    localparam int HALF_WINDOW = 96;           // one and a half bins

    typedef logic [NB-1:0]      coarseBin_t;
    typedef logic [NP-1:0]      fineTime_t;
    typedef logic [PIXEL_W-1:0] pixelIdx_t;
    typedef logic [COUNT_W-1:0] binCount_t;

    // one TDC sample, already reduced to a coarse bin
    typedef struct packed {
        pixelIdx_t  pixel;
        coarseBin_t coarse;
    } tdcSample_t;

    typedef struct packed {
        pixelIdx_t  pixel;
        coarseBin_t peakCH;     // bin with the highest count
        binCount_t  peakCount;
    } peakResult_t;

    typedef struct packed {
        fineTime_t thMinus;     // lower edge of the window
        fineTime_t thPositive;  // upper edge
        fineTime_t delta;       // lower edge within its bin
    } threshold_t;

    typedef struct packed {
        pixelIdx_t  pixel;
        threshold_t window;
    } thresholdWrite_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        REPORT
    } searchState_t;

endpackage

`default_nettype wire

/* coarseHist/histogramBank.sv */
`timescale 1ns/1ps
`default_nettype none

module histogramBank (
    input  wire logic                clk,
    input  wire logic                res,
    input  wire logic                sampleValid,
    input  wire sifhPkg::tdcSample_t sample,
    input  wire sifhPkg::pixelIdx_t  curPixel,
    input  wire logic                busy,
    input  wire logic                scanEn,
    input  wire sifhPkg::coarseBin_t scanAddr,
    output sifhPkg::binCount_t       scanCount
);

    sifhPkg::binCount_t binCnt [sifhPkg::BIN_NUM];  // one counter per coarse bin
    logic               countHit;
    logic               binFull;

    // only samples of the pixel being collected, and never during a scan
    assign countHit = sampleValid && !busy && (sample.pixel == curPixel);
    assign binFull  = (binCnt[sample.coarse] == '1);  // saturated at 255

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::BIN_NUM; i++) begin
                binCnt[i] <= '0;
            end
            scanCount <= '0;
        end else begin
            if (scanEn) begin
                scanCount        <= binCnt[scanAddr];  // one cycle read latency
                binCnt[scanAddr] <= '0;                // clear on read
            end else if (countHit && !binFull) begin
                binCnt[sample.coarse] <= binCnt[sample.coarse] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* coarseHist/peakSearch.sv */
`timescale 1ns/1ps
`default_nettype none

module peakSearch (
    input  wire logic                 clk,
    input  wire logic                 res,
    input  wire logic                 pixelEnd,
    input  wire sifhPkg::pixelIdx_t   endPixel,
    input  wire sifhPkg::binCount_t   scanCount,
    output logic                      scanEn,
    output sifhPkg::coarseBin_t       scanAddr,
    output logic                      busy,
    output sifhPkg::pixelIdx_t        curPixel,
    output logic                      peakDone,
    output sifhPkg::peakResult_t      peak
);

    sifhPkg::searchState_t state;
    logic [sifhPkg::NB:0]  scanCnt;     // top bit set once all bins are issued
    logic                  cmpValid;    // scanCount holds a bin this cycle
    sifhPkg::coarseBin_t   cmpIdx;      // which bin that is
    sifhPkg::coarseBin_t   bestIdx;
    sifhPkg::binCount_t    bestCount;
    sifhPkg::pixelIdx_t    pixelLatch;  // pixel whose histogram is scanned
    logic                  startScan;

    assign scanEn    = (state == sifhPkg::SCAN) && !scanCnt[sifhPkg::NB];
    assign scanAddr  = scanCnt[sifhPkg::NB-1:0];
    assign busy      = (state != sifhPkg::IDLE) || peakDone;  // through the strobe
    assign startScan = (state == sifhPkg::IDLE) && pixelEnd && !peakDone;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= sifhPkg::IDLE;
            scanCnt    <= '0;
            cmpValid   <= 1'b0;
            cmpIdx     <= '0;
            bestIdx    <= '0;
            bestCount  <= '0;
            pixelLatch <= '0;
            curPixel   <= '0;
            peakDone   <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            cmpValid <= scanEn;      // follows the bank read latency
            cmpIdx   <= scanAddr;

            // strict compare, so the lowest bin keeps a tie
            if (cmpValid && (scanCount > bestCount)) begin
                bestCount <= scanCount;
                bestIdx   <= cmpIdx;
            end

            case (state)
                sifhPkg::IDLE: begin
                    if (startScan) begin
                        state      <= sifhPkg::SCAN;
                        scanCnt    <= '0;
                        bestCount  <= '0;
                        bestIdx    <= '0;
                        pixelLatch <= endPixel;
                        curPixel   <= endPixel + sifhPkg::pixelIdx_t'(1);  // next pixel
                    end
                end
                sifhPkg::SCAN: begin
                    if (scanCnt[sifhPkg::NB]) begin
                        state <= sifhPkg::REPORT;  // last compare lands this edge
                    end else begin
                        scanCnt <= scanCnt + 1'b1;
                    end
                end
                sifhPkg::REPORT: begin
                    state    <= sifhPkg::IDLE;
                    peakDone <= 1'b1;
                end
                default: begin
                    state <= sifhPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sifhPkg::REPORT) begin
            peak.pixel     <= pixelLatch;
            peak.peakCH    <= bestIdx;
            peak.peakCount <= bestCount;
        end
    end

endmodule

`default_nettype wire

/* algebraic/algebraicBlock.sv */
`timescale 1ns/1ps
`default_nettype none

module algebraicBlock (
    input  wire logic                  clk,
    input  wire logic                  res,
    input  wire logic                  peakDone,
    input  wire sifhPkg::peakResult_t  peak,
    output logic                       thWrite,
    output sifhPkg::thresholdWrite_t   thData
);

    sifhPkg::fineTime_t centre;     // middle of the peak bin in fine steps
    sifhPkg::fineTime_t halfWin;
    sifhPkg::fineTime_t fineMax;
    sifhPkg::fineTime_t binMask;
    sifhPkg::fineTime_t lowerTh;
    sifhPkg::fineTime_t upperTh;

    assign halfWin = sifhPkg::fineTime_t'(sifhPkg::HALF_WINDOW);
    assign fineMax = '1;                                        // 1023
    assign binMask = sifhPkg::fineTime_t'(sifhPkg::BIN_WIDTH - 1);

    assign centre = (sifhPkg::fineTime_t'(peak.peakCH) << sifhPkg::FINE_SHIFT)
                  + sifhPkg::fineTime_t'(sifhPkg::BIN_WIDTH / 2);

    always_comb begin
        if (centre <= halfWin) begin
            // window would start below zero
            lowerTh = '0;
            upperTh = halfWin + halfWin;
        end else if (centre >= (fineMax - halfWin)) begin
            // pinned to the end of the fine range
            upperTh = fineMax;
            lowerTh = fineMax - halfWin - halfWin;
        end else begin
            lowerTh = centre - halfWin;
            upperTh = centre + halfWin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            thWrite <= 1'b0;
        end else begin
            thWrite <= peakDone;  // exactly one cycle behind
        end
    end

    always_ff @(posedge clk) begin
        if (peakDone) begin
            thData.pixel             <= peak.pixel;
            thData.window.thMinus    <= lowerTh;
            thData.window.thPositive <= upperTh;
            thData.window.delta      <= lowerTh & binMask;  // modulo bin width
        end
    end

endmodule

`default_nettype wire

/* algebraic/thresholdStore.sv */
`timescale 1ns/1ps
`default_nettype none

module thresholdStore (
    input  wire logic                      clk,
    input  wire logic                      res,
    input  wire logic                      thWrite,
    input  wire sifhPkg::thresholdWrite_t  thData,
    input  wire logic                      frameStart,
    input  wire sifhPkg::pixelIdx_t        rdPixel,
    output sifhPkg::threshold_t            rdWindow,
    output logic                           frameReady
);

    sifhPkg::threshold_t          windows [sifhPkg::PIXEL_NUM];
    logic [sifhPkg::PIXEL_NUM-1:0] written;  // one bit per pixel of the frame

    assign rdWindow = windows[rdPixel];     // plain read port

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::PIXEL_NUM; i++) begin
                windows[i] <= '0;
            end
        end else if (thWrite) begin
            windows[thData.pixel] <= thData.window;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            written    <= '0;
            frameReady <= 1'b0;
        end else begin
            if (frameStart) begin
                written <= '0;  // windows themselves are kept
            end else if (thWrite) begin
                written[thData.pixel] <= 1'b1;
            end
            frameReady <= (&written) && !frameStart;  // one cycle after the last write
        end
    end

endmodule

`default_nettype wire

/* rtl/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire logic                 clk,
    input  wire logic                 res,
    input  wire logic                 sampleValid,
    input  wire sifhPkg::tdcSample_t  sample,
    input  wire logic                 pixelEnd,
    input  wire sifhPkg::pixelIdx_t   endPixel,
    input  wire logic                 frameStart,
    input  wire sifhPkg::pixelIdx_t   rdPixel,
    output sifhPkg::threshold_t       rdWindow,
    output logic                      frameReady,
    output logic                      busy,
    output logic                      peakDone,
    output sifhPkg::peakResult_t      peak
);

    logic                      scanEn;
    sifhPkg::coarseBin_t       scanAddr;
    sifhPkg::binCount_t        scanCount;
    sifhPkg::pixelIdx_t        curPixel;   // pixel being collected
    logic                      thWrite;
    sifhPkg::thresholdWrite_t  thData;

    histogramBank u_histogramBank (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .curPixel    (curPixel),
        .busy        (busy),
        .scanEn      (scanEn),
        .scanAddr    (scanAddr),
        .scanCount   (scanCount)
    );

    peakSearch u_peakSearch (
        .clk       (clk),
        .res       (res),
        .pixelEnd  (pixelEnd),
        .endPixel  (endPixel),
        .scanCount (scanCount),
        .scanEn    (scanEn),
        .scanAddr  (scanAddr),
        .busy      (busy),
        .curPixel  (curPixel),
        .peakDone  (peakDone),
        .peak      (peak)
    );

    algebraicBlock u_algebraicBlock (
        .clk      (clk),
        .res      (res),
        .peakDone (peakDone),
        .peak     (peak),
        .thWrite  (thWrite),
        .thData   (thData)
    );

    thresholdStore u_thresholdStore (
        .clk        (clk),
        .res        (res),
        .thWrite    (thWrite),
        .thData     (thData),
        .frameStart (frameStart),
        .rdPixel    (rdPixel),
        .rdWindow   (rdWindow),
        .frameReady (frameReady)
    );

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

    initial begin
        res = 1'b0;
        repeat (3) @(posedge clk);
        res <= 1'b1;  // released after three cycles
    end

endmodule

`default_nettype wire

/* testbench/sifhTop_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTopAssert (
    input wire logic                     clk,
    input wire logic                     res,
    input wire logic                     pixelEnd,
    input wire logic                     busy,
    input wire logic                     peakDone,
    input wire logic                     thWrite,
    input wire sifhPkg::thresholdWrite_t thData,
    input wire sifhPkg::searchState_t    searchState
);

    // the bank has no queue so a second pixelEnd during a scan is lost
    noEndWhileBusy: assert property (@(posedge clk) disable iff (!res)
        pixelEnd |-> !busy)
        else $error("pixelEnd arrived while the peak search was busy");

    writeFollowsDone: assert property (@(posedge clk) disable iff (!res)
        peakDone |=> thWrite)
        else $error("thWrite did not follow peakDone by one cycle");

    // 16 reads plus the last compare, then one cycle in REPORT
    scanLength: assert property (@(posedge clk) disable iff (!res)
        $rose(busy) |-> ##17 (searchState == sifhPkg::REPORT) ##1 peakDone)
        else $error("peak search did not reach REPORT and peakDone in time");

    windowOrdered: assert property (@(posedge clk) disable iff (!res)
        thWrite |-> (thData.window.thMinus <= thData.window.thPositive))
        else $error("window lower edge above its upper edge");

endmodule

bind sifhTop sifhTopAssert u_sifhTopAssert (
    .clk         (clk),
    .res         (res),
    .pixelEnd    (pixelEnd),
    .busy        (busy),
    .peakDone    (peakDone),
    .thWrite     (thWrite),
    .thData      (thData),
    .searchState (u_peakSearch.state)
);

`default_nettype wire

/* testbench/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    logic                 clk;
    logic                 res;
    logic                 sampleValid;
    sifhPkg::tdcSample_t  sample;
    logic                 pixelEnd;
    sifhPkg::pixelIdx_t   endPixel;
    logic                 frameStart;
    sifhPkg::pixelIdx_t   rdPixel;
    sifhPkg::threshold_t  rdWindow;
    logic                 frameReady;
    logic                 busy;
    logic                 peakDone;
    sifhPkg::peakResult_t peak;

    int                  modelHist [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM];
    sifhPkg::threshold_t modelWin  [sifhPkg::PIXEL_NUM];  // what the store should hold
    sifhPkg::pixelIdx_t  modelCur;                        // pixel the bank collects
    int                  forcedBins [4] = '{0, 1, 14, 15};
    int                  errorCount;

    clockGen u_clockGen (
        .clk (clk),
        .res (res)
    );

    sifhTop u_sifhTop (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .pixelEnd    (pixelEnd),
        .endPixel    (endPixel),
        .frameStart  (frameStart),
        .rdPixel     (rdPixel),
        .rdWindow    (rdWindow),
        .frameReady  (frameReady),
        .busy        (busy),
        .peakDone    (peakDone),
        .peak        (peak)
    );

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            errorCount++;
            $display("** Error at time %0t: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        errorCount++;
        $display("Timeout at time %0t: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on a timeout");
    endtask

    // centre of the bin plus or minus HALF_WINDOW, clamped to the fine range
    function automatic sifhPkg::threshold_t windowFor(input int bin);
        sifhPkg::threshold_t w;
        int ch;
        int lo;
        int hi;
        int fineMax;
        fineMax = (1 << sifhPkg::NP) - 1;
        ch = bin * sifhPkg::BIN_WIDTH + sifhPkg::BIN_WIDTH / 2;
        if (ch <= sifhPkg::HALF_WINDOW) begin
            lo = 0;
            hi = 2 * sifhPkg::HALF_WINDOW;
        end else if (ch >= fineMax - sifhPkg::HALF_WINDOW) begin
            hi = fineMax;
            lo = fineMax - 2 * sifhPkg::HALF_WINDOW;
        end else begin
            lo = ch - sifhPkg::HALF_WINDOW;
            hi = ch + sifhPkg::HALF_WINDOW;
        end
        w.thMinus    = sifhPkg::fineTime_t'(lo);
        w.thPositive = sifhPkg::fineTime_t'(hi);
        w.delta      = sifhPkg::fineTime_t'(lo % sifhPkg::BIN_WIDTH);
        return w;
    endfunction

    task automatic checkWindow(input sifhPkg::threshold_t expWin);
        checkValue("rdWindow.thMinus", int'(rdWindow.thMinus), int'(expWin.thMinus));
        checkValue("rdWindow.thPositive", int'(rdWindow.thPositive), int'(expWin.thPositive));
        checkValue("rdWindow.delta", int'(rdWindow.delta), int'(expWin.delta));
    endtask

    task automatic sendSample(input sifhPkg::pixelIdx_t pix, input int bin);
        @(posedge clk);
        sampleValid   <= 1'b1;
        sample.pixel  <= pix;
        sample.coarse <= sifhPkg::coarseBin_t'(bin);
        if ((pix == modelCur) && (modelHist[pix][bin] < 255)) begin
            modelHist[pix][bin]++;  // saturating like the bank
        end
    endtask

    task automatic sendRandom();
        sifhPkg::pixelIdx_t pix;
        pix = modelCur;
        if ($urandom % 5 == 0) begin
            pix = modelCur + sifhPkg::pixelIdx_t'(1 + $urandom % 7);  // some other pixel
        end
        sendSample(pix, int'($urandom % sifhPkg::BIN_NUM));
    endtask

    // mode 0 random, 1 saturate a bin, 2 tie of two bins, 3 forced peak
    task automatic fillPixel(input int mode, input int bin);
        int n;
        int binA;
        int binB;
        n = 10 + int'($urandom % 30);
        for (int i = 0; i < n; i++) begin
            sendRandom();
        end
        case (mode)
            1: repeat (300) sendSample(modelCur, bin);
            2: begin
                binA = int'($urandom % 8);
                binB = binA + 1 + int'($urandom % 7);
                while (modelHist[modelCur][binB] < 60) sendSample(modelCur, binB);
                while (modelHist[modelCur][binA] < 60) sendSample(modelCur, binA);
            end
            3: repeat (45) sendSample(modelCur, bin);
            default: ;
        endcase
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    task automatic closePixel();
        sifhPkg::pixelIdx_t  p;
        sifhPkg::threshold_t expWin;
        sifhPkg::threshold_t oldWin;
        int                  bestBin;
        int                  bestCnt;
        int                  cyc;
        p       = modelCur;
        bestBin = 0;
        bestCnt = 0;
        for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
            if (modelHist[p][b] > bestCnt) begin  // lowest bin wins a tie
                bestCnt = modelHist[p][b];
                bestBin = b;
            end
        end
        expWin = windowFor(bestBin);
        oldWin = modelWin[p];
        @(posedge clk);
        pixelEnd <= 1'b1;
        endPixel <= p;
        rdPixel  <= p;
        @(posedge clk);  // DUT takes pixelEnd here
        pixelEnd <= 1'b0;
        @(negedge clk);
        checkValue("busy", int'(busy), 1);
        cyc = 0;
        while (!peakDone) begin
            @(posedge clk);
            sampleValid   <= 1'b1;  // must be dropped while busy
            sample.pixel  <= p + sifhPkg::pixelIdx_t'(1);
            sample.coarse <= sifhPkg::coarseBin_t'($urandom);
            @(negedge clk);
            cyc++;
            if (cyc > 100) timeoutFail("peakDone never came after pixelEnd");
        end
        checkValue("peakDone latency", cyc, 18);
        checkValue("peak.pixel", int'(peak.pixel), int'(p));
        checkValue("peak.peakCH", int'(peak.peakCH), bestBin);
        checkValue("peak.peakCount", int'(peak.peakCount), bestCnt);
        for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
            modelHist[p][b] = 0;
        end
        modelCur = p + sifhPkg::pixelIdx_t'(1);
        @(posedge clk);
        sampleValid <= 1'b0;
        @(negedge clk);
        checkValue("busy", int'(busy), 0);
        checkWindow(oldWin);  // not yet written at cycle 19
        @(negedge clk);
        checkWindow(expWin);
        checkValue("frameReady", int'(frameReady), 0);
        modelWin[p] = expWin;
    endtask

    task automatic runFrame(input logic firstFrame);
        int mode;
        int bin;
        int cyc;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            if (!firstFrame) begin
                mode = int'($urandom % 4);
                bin  = int'($urandom % sifhPkg::BIN_NUM);
            end else if (p >= 4) begin
                mode = 3;
                bin  = forcedBins[p - 4];  // both clamp branches
            end else begin
                mode = (p == 2) ? 1 : (p == 3) ? 2 : 0;
                bin  = int'($urandom % sifhPkg::BIN_NUM);
            end
            fillPixel(mode, bin);
            closePixel();
        end
        cyc = 0;
        while (!frameReady) begin
            @(negedge clk);
            cyc++;
            if (cyc > 100) timeoutFail("frameReady did not rise after a full frame");
        end
        checkValue("frameReady latency", cyc, 1);
    endtask

    task automatic readBack();
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            @(posedge clk);
            rdPixel <= sifhPkg::pixelIdx_t'(p);
            @(negedge clk);
            checkWindow(modelWin[p]);
        end
    endtask

    initial begin
        int cyc;
        void'($urandom(18));
        errorCount  = 0;
        modelCur    = '0;
        sampleValid = 1'b0;
        sample      = '0;
        pixelEnd    = 1'b0;
        endPixel    = '0;
        frameStart  = 1'b0;
        rdPixel     = '0;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            modelWin[p] = '0;
            for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
                modelHist[p][b] = 0;
            end
        end

        cyc = 0;
        while (!res) begin
            @(negedge clk);
            cyc++;
            if (cyc > 20) timeoutFail("reset was never released");
        end
        checkValue("busy", int'(busy), 0);
        checkValue("peakDone", int'(peakDone), 0);
        checkValue("frameReady", int'(frameReady), 0);
        readBack();  // all windows zero after reset

        runFrame(1'b1);
        readBack();

        @(posedge clk);
        frameStart <= 1'b1;
        @(posedge clk);
        frameStart <= 1'b0;
        @(negedge clk);
        checkValue("frameReady", int'(frameReady), 0);
        readBack();  // windows survive frameStart

        runFrame(1'b0);
        readBack();

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/sifhPkg.sv
coarseHist/histogramBank.sv
coarseHist/peakSearch.sv
algebraic/algebraicBlock.sv
algebraic/thresholdStore.sv
rtl/sifhTop.sv
testbench/clockGen.sv
testbench/sifhTop_assert.sv
testbench/sifhTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module sifhTb \
    -Mdir obj_dir -o sifhSim

./obj_dir/sifhSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
